// ==== files.f ====
rtl/l2c_cfg_pkg.sv
rtl/l2c_msg_pkg.sv
rtl/l2c_slot_alloc.sv
rtl/l2c_req_slot.sv
rtl/l2c_tag_dir.sv
rtl/l2c_line_mem.sv
rtl/l2c_ans_sel.sv
rtl/l2c_emulator_top.sv
testbench/tb_l2c_emulator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the L2 cache emulator testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_l2c_emulator -f files.f -o vsim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi
exit 0

// ==== testbench/tb_l2c_emulator.sv ====
// ************************************************
// Testbench for the L2 cache emulator
// Drives the arbiter channels and checks every answer
// against a memory, tag and request model
// ************************************************
module tb_l2c_emulator
  import l2c_cfg_pkg::*;
  import l2c_msg_pkg::*;
();

  localparam int WAIT_MAX = 300;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 req_valid_i;
  l2c_req_e             req_type_i;
  logic [PADDR_W-1:0]   req_paddr_i;
  logic [WBB_TAG_W-1:0] req_wbb_tag_i;
  logic [LINE_W-1:0]    req_line_i;
  logic                 req_rdy_o;
  logic                 ans_valid_o;
  l2c_ans_e             ans_type_o;
  logic [PADDR_W-1:0]   ans_paddr_o;
  logic [WBB_TAG_W-1:0] ans_wbb_tag_o;
  logic [LINE_W-1:0]    ans_line_o;
  logic [DW_W-1:0]      ans_data_o;
  logic                 ans_rdy_i;

  // Memory and tag directory model
  logic [LINE_W-1:0]    mem_mdl [MEM_LINES];
  logic                 tag_vld [SET_NUM];
  logic [TAG_W-1:0]     tag_mdl [SET_NUM];
  // Outstanding requests with their expected answers
  logic [PADDR_W-1:0]   q_paddr [$];
  l2c_ans_e             q_type [$];
  logic [WBB_TAG_W-1:0] q_wbb [$];
  logic [LINE_W-1:0]    q_line [$];
  logic [DW_W-1:0]      q_data [$];
  // Paddrs in the order their answers were consumed
  logic [PADDR_W-1:0]   done_paddr [$];

  // Answer seen while stalled
  logic                 held;
  l2c_ans_e             snap_type;
  logic [PADDR_W-1:0]   snap_paddr;
  logic [WBB_TAG_W-1:0] snap_wbb;
  logic [LINE_W-1:0]    snap_line;
  logic [DW_W-1:0]      snap_data;

  int                   seed;
  int                   errors;
  int                   checks;
  logic                 chk_en;
  logic                 bp_on;
  logic [63:0]          bp_pat;
  logic [5:0]           bp_idx;

  l2c_emulator_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .req_valid_i   (req_valid_i),
    .req_type_i    (req_type_i),
    .req_paddr_i   (req_paddr_i),
    .req_wbb_tag_i (req_wbb_tag_i),
    .req_line_i    (req_line_i),
    .req_rdy_o     (req_rdy_o),
    .ans_valid_o   (ans_valid_o),
    .ans_type_o    (ans_type_o),
    .ans_paddr_o   (ans_paddr_o),
    .ans_wbb_tag_o (ans_wbb_tag_o),
    .ans_line_o    (ans_line_o),
    .ans_data_o    (ans_data_o),
    .ans_rdy_i     (ans_rdy_i)
  );

  always #2 clk_i = ~clk_i;

  // Arbiter ready follows a random pattern while back-pressure is on
  always @(posedge clk_i) begin
    #1;
    if (bp_on) begin
      ans_rdy_i = bp_pat[bp_idx];
      bp_idx    = bp_idx + 6'd1;
    end else begin
      ans_rdy_i = 1'b1;
    end
  end

  task automatic check_val(input string name, input logic [LINE_W-1:0] got,
                           input logic [LINE_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    errors++;
    $display("TIMEOUT at %0t: %s", $time, what);
    finish_run();
  endtask

  // Expected answer computed at accept time
  task automatic model_accept();
    logic [MEM_IDX_W-1:0] idx;
    logic [SET_W-1:0]     set_idx;
    logic [TAG_W-1:0]     tag;
    logic [OFF_W-1:0]     off;
    logic                 miss;
    l2c_ans_e             typ;
    logic [WBB_TAG_W-1:0] wbb;
    logic [LINE_W-1:0]    line;
    logic [DW_W-1:0]      data;
    idx     = req_paddr_i[LINE_LSB +: MEM_IDX_W];
    set_idx = req_paddr_i[LINE_LSB +: SET_W];
    tag     = req_paddr_i[TAG_LSB +: TAG_W];
    off     = req_paddr_i[OFF_LSB +: OFF_W];
    // Lookup first, then every request allocates its set
    miss    = !tag_vld[set_idx] || (tag_mdl[set_idx] != tag);
    tag_vld[set_idx] = 1'b1;
    tag_mdl[set_idx] = tag;
    if (req_type_i == DWriteLine) begin
      mem_mdl[idx] = req_line_i;
    end
    typ  = ILineRead;
    wbb  = '0;
    line = '0;
    data = '0;
    case (req_type_i)
      IReadLine: begin
        line = mem_mdl[idx];
      end
      DReadLine: begin
        typ  = DLineRead;
        line = mem_mdl[idx];
      end
      DWriteLine: begin
        typ = miss ? DWbbWakeUp : DLineWritten;
        wbb = req_wbb_tag_i;
      end
      PTWLoad: begin
        typ  = PTWLoadDone;
        data = mem_mdl[idx][off*DW_W +: DW_W];
      end
    endcase
    q_paddr.push_back(req_paddr_i);
    q_type.push_back(typ);
    q_wbb.push_back(wbb);
    q_line.push_back(line);
    q_data.push_back(data);
  endtask

  task automatic drop_entry(input int pos);
    q_paddr.delete(pos);
    q_type.delete(pos);
    q_wbb.delete(pos);
    q_line.delete(pos);
    q_data.delete(pos);
  endtask

  // Monitor samples at the falling edge where all outputs have settled
  always @(negedge clk_i) begin
    int busy_cnt;
    int hit_cnt;
    int hit_pos;
    if (rst_ni && chk_en) begin
      // Entries in flight minus the one in the answer register
      busy_cnt = q_paddr.size() - (ans_valid_o ? 1 : 0);
      check_val("req_rdy_o", req_rdy_o, busy_cnt < BUF_LEN);
      if (held) begin
        check_val("ans_valid_o", ans_valid_o, 1'b1);
        check_val("ans_type_o", ans_type_o, snap_type);
        check_val("ans_paddr_o", ans_paddr_o, snap_paddr);
        check_val("ans_wbb_tag_o", ans_wbb_tag_o, snap_wbb);
        check_val("ans_line_o", ans_line_o, snap_line);
        check_val("ans_data_o", ans_data_o, snap_data);
      end
      held       = ans_valid_o && !ans_rdy_i;
      snap_type  = ans_type_o;
      snap_paddr = ans_paddr_o;
      snap_wbb   = ans_wbb_tag_o;
      snap_line  = ans_line_o;
      snap_data  = ans_data_o;
      // Answer taken on the coming edge
      if (ans_valid_o && ans_rdy_i) begin
        hit_cnt = 0;
        hit_pos = 0;
        foreach (q_paddr[k]) begin
          if (q_paddr[k] == ans_paddr_o) begin
            hit_cnt++;
            hit_pos = k;
          end
        end
        checks++;
        assert (hit_cnt == 1) else begin
          errors++;
          $display("ERROR at %0t: answer for paddr %0h matches %0d outstanding requests",
                   $time, ans_paddr_o, hit_cnt);
        end
        if (hit_cnt == 1) begin
          check_val("ans_type_o", ans_type_o, q_type[hit_pos]);
          check_val("ans_wbb_tag_o", ans_wbb_tag_o, q_wbb[hit_pos]);
          check_val("ans_line_o", ans_line_o, q_line[hit_pos]);
          check_val("ans_data_o", ans_data_o, q_data[hit_pos]);
          drop_entry(hit_pos);
        end
        done_paddr.push_back(ans_paddr_o);
      end
      // Flush drops every request and the held answer and lets no new one in
      if (flush_i) begin
        q_paddr.delete();
        q_type.delete();
        q_wbb.delete();
        q_line.delete();
        q_data.delete();
        held = 1'b0;
      end else if (req_valid_i && req_rdy_o) begin
        model_accept();
      end
    end
  end

  function automatic logic [LINE_W-1:0] rand_line();
    logic [LINE_W-1:0] line;
    for (int k = 0; k < LINE_W / 32; k++) begin
      line[k*32 +: 32] = $random(seed);
    end
    return line;
  endfunction

  function automatic logic [WBB_TAG_W-1:0] rand_wbb();
    logic [31:0] r;
    r = $random(seed);
    return r[WBB_TAG_W-1:0];
  endfunction

  function automatic int last_pos(input logic [PADDR_W-1:0] addr);
    int pos;
    pos = -1;
    foreach (done_paddr[k]) begin
      if (done_paddr[k] == addr) begin
        pos = k;
      end
    end
    return pos;
  endfunction

  // Called just after a rising edge and returns just after the accept edge
  task automatic send_req(input l2c_req_e typ, input logic [PADDR_W-1:0] addr,
                          input logic [WBB_TAG_W-1:0] wbb, input logic [LINE_W-1:0] line);
    int n;
    req_valid_i   = 1'b1;
    req_type_i    = typ;
    req_paddr_i   = addr;
    req_wbb_tag_i = wbb;
    req_line_i    = line;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!req_rdy_o && n < WAIT_MAX);
    if (!req_rdy_o) begin
      fail_timeout("request was never accepted");
    end else begin
      @(posedge clk_i);
      #1;
      req_valid_i = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (q_paddr.size() != 0 && n < WAIT_MAX) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (q_paddr.size() != 0) begin
      fail_timeout("outstanding requests were never answered");
    end
  endtask

  // Returns just after the edge that made an answer valid
  task automatic wait_answer();
    int n;
    n = 0;
    while (!ans_valid_o && n < WAIT_MAX) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (!ans_valid_o) begin
      fail_timeout("answer never became valid");
    end
  endtask

  initial begin
    logic [PADDR_W-1:0] base;
    logic [OFF_W-1:0]   off;
    seed          = 32'h8067_42bf;
    errors        = 0;
    checks        = 0;
    chk_en        = 1'b0;
    held          = 1'b0;
    bp_on         = 1'b0;
    bp_idx        = '0;
    bp_pat        = '0;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    req_valid_i   = 1'b0;
    req_type_i    = IReadLine;
    req_paddr_i   = '0;
    req_wbb_tag_i = '0;
    req_line_i    = '0;
    ans_rdy_i     = 1'b1;
    for (int s = 0; s < SET_NUM; s++) begin
      tag_vld[s] = 1'b0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_val("ans_valid_o", ans_valid_o, 1'b0);
    check_val("req_rdy_o", req_rdy_o, 1'b1);
    @(posedge clk_i);
    #1;
    chk_en = 1'b1;

    // Write twice (miss then hit), then read back through both ports
    for (int i = 0; i < 4; i++) begin
      base = 32'h0000_2000 + 32'(i * 64);
      send_req(DWriteLine, base, rand_wbb(), rand_line());
      wait_idle();
      send_req(DWriteLine, base, rand_wbb(), rand_line());
      wait_idle();
      send_req(IReadLine, base, '0, '0);
      send_req(DReadLine, base + 32'd8, '0, '0);
      wait_idle();
    end

    // Page-table loads pick one doubleword
    for (int i = 0; i < 4; i++) begin
      off = OFF_W'(2 * i + 3);
      send_req(PTWLoad, 32'h0000_2000 + 32'(i * 64) + 32'(off) * 8, '0, '0);
    end
    wait_idle();

    // Hit right behind a miss leaves first
    send_req(DWriteLine, 32'h0008_0300, rand_wbb(), rand_line());
    send_req(IReadLine, 32'h0000_2010, '0, '0);
    wait_idle();
    checks++;
    assert (last_pos(32'h0000_2010) < last_pos(32'h0008_0300)) else begin
      errors++;
      $display("ERROR at %0t: hit answer did not overtake the earlier miss", $time);
    end

    // Random stalls with the slots kept full
    bp_pat = {$random(seed), $random(seed)};
    @(negedge clk_i);
    bp_on = 1'b1;
    @(posedge clk_i);
    #1;
    for (int k = 0; k < 8; k++) begin
      send_req(DReadLine, 32'h0000_2020 + 32'((k % 4) * 64 + (k / 4) * 8), '0, '0);
      send_req(DWriteLine, 32'h0000_0400 + 32'(k * 64), rand_wbb(), rand_line());
    end
    wait_idle();
    @(negedge clk_i);
    bp_on = 1'b0;
    @(posedge clk_i);
    #1;

    // Stalled answer plus two misses, all dropped by the flush
    @(negedge clk_i);
    bp_pat = '0;
    bp_on  = 1'b1;
    @(posedge clk_i);
    #1;
    send_req(IReadLine, 32'h0000_2000, '0, '0);
    wait_answer();
    send_req(DWriteLine, 32'h0010_0800, rand_wbb(), rand_line());
    send_req(DWriteLine, 32'h0010_0840, rand_wbb(), rand_line());
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    check_val("ans_valid_o", ans_valid_o, 1'b0);
    for (int c = 0; c < M_DELAY + 4; c++) begin
      @(negedge clk_i);
      check_val("ans_valid_o", ans_valid_o, 1'b0);
    end
    bp_on = 1'b0;
    @(posedge clk_i);
    #1;
    check_val("req_rdy_o", req_rdy_o, 1'b1);

    finish_run();
  end

endmodule

// ==== rtl/l2c_emulator_top.sv ====
// ************************************************
// L2 cache emulator top level
// Non-blocking responder for the L2 arbiter channels
// ************************************************
module l2c_emulator_top
  import l2c_cfg_pkg::*;
  import l2c_msg_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Request channel from the arbiter
  input  logic                 req_valid_i,
  input  l2c_req_e             req_type_i,
  input  logic [PADDR_W-1:0]   req_paddr_i,
  input  logic [WBB_TAG_W-1:0] req_wbb_tag_i,
  input  logic [LINE_W-1:0]    req_line_i,
  output logic                 req_rdy_o,
  // Answer channel to the arbiter
  output logic                 ans_valid_o,
  output l2c_ans_e             ans_type_o,
  output logic [PADDR_W-1:0]   ans_paddr_o,
  output logic [WBB_TAG_W-1:0] ans_wbb_tag_o,
  output logic [LINE_W-1:0]    ans_line_o,
  output logic [DW_W-1:0]      ans_data_o,
  input  logic                 ans_rdy_i
);

  logic [BUF_LEN-1:0]   load;
  logic [BUF_LEN-1:0]   retire;
  logic [BUF_LEN-1:0]   busy;
  logic [BUF_LEN-1:0]   expired;
  logic [BUF_LEN-1:0]   slot_miss;
  l2c_req_e             slot_type    [BUF_LEN];
  logic [PADDR_W-1:0]   slot_paddr   [BUF_LEN];
  logic [WBB_TAG_W-1:0] slot_wbb_tag [BUF_LEN];
  logic                 accept;
  logic                 req_miss;
  logic                 mem_we;
  logic [MEM_IDX_W-1:0] mem_ridx;
  logic [LINE_W-1:0]    mem_rline;

  // Handshake on the request channel, blocked while flushing
  assign accept = req_valid_i && req_rdy_o && !flush_i;
  // Line writes reach memory right away
  assign mem_we = accept && (req_type_i == DWriteLine);

  l2c_slot_alloc u_alloc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_valid_i (req_valid_i),
    .busy_i      (busy),
    .load_o      (load),
    .req_rdy_o   (req_rdy_o)
  );

  l2c_tag_dir u_tag_dir (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .accept_i (accept),
    .paddr_i  (req_paddr_i),
    .miss_o   (req_miss)
  );

  l2c_line_mem u_mem (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .widx_i  (req_paddr_i[LINE_LSB +: MEM_IDX_W]),
    .wline_i (req_line_i),
    .ridx_i  (mem_ridx),
    .rline_o (mem_rline)
  );

  // Outstanding request slots
  for (genvar i = 0; i < BUF_LEN; i++) begin : g_slot
    l2c_req_slot u_slot (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .load_i     (load[i]),
      .retire_i   (retire[i]),
      .req_type_i (req_type_i),
      .paddr_i    (req_paddr_i),
      .wbb_tag_i  (req_wbb_tag_i),
      .miss_i     (req_miss),
      .busy_o     (busy[i]),
      .expired_o  (expired[i]),
      .type_o     (slot_type[i]),
      .paddr_o    (slot_paddr[i]),
      .wbb_tag_o  (slot_wbb_tag[i]),
      .miss_o     (slot_miss[i])
    );
  end

  l2c_ans_sel u_ans_sel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .expired_i     (expired),
    .type_i        (slot_type),
    .paddr_i       (slot_paddr),
    .wbb_tag_i     (slot_wbb_tag),
    .miss_i        (slot_miss),
    .rline_i       (mem_rline),
    .ans_rdy_i     (ans_rdy_i),
    .ridx_o        (mem_ridx),
    .retire_o      (retire),
    .ans_valid_o   (ans_valid_o),
    .ans_type_o    (ans_type_o),
    .ans_paddr_o   (ans_paddr_o),
    .ans_wbb_tag_o (ans_wbb_tag_o),
    .ans_line_o    (ans_line_o),
    .ans_data_o    (ans_data_o)
  );

endmodule

// ==== rtl/l2c_ans_sel.sv ====
// ************************************************
// L2 cache emulator answer selector
// Retires the lowest expired slot into the answer register
// Holds the answer while the arbiter stalls
// ************************************************
module l2c_ans_sel
  import l2c_cfg_pkg::*;
  import l2c_msg_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic [BUF_LEN-1:0]   expired_i,
  input  l2c_req_e             type_i    [BUF_LEN],
  input  logic [PADDR_W-1:0]   paddr_i   [BUF_LEN],
  input  logic [WBB_TAG_W-1:0] wbb_tag_i [BUF_LEN],
  input  logic [BUF_LEN-1:0]   miss_i,
  input  logic [LINE_W-1:0]    rline_i,
  input  logic                 ans_rdy_i,
  output logic [MEM_IDX_W-1:0] ridx_o,
  output logic [BUF_LEN-1:0]   retire_o,
  output logic                 ans_valid_o,
  output l2c_ans_e             ans_type_o,
  output logic [PADDR_W-1:0]   ans_paddr_o,
  output logic [WBB_TAG_W-1:0] ans_wbb_tag_o,
  output logic [LINE_W-1:0]    ans_line_o,
  output logic [DW_W-1:0]      ans_data_o
);

  logic [BUF_IDX_W-1:0]               sel_idx;
  logic                               sel_vld;
  logic                               take;
  logic [DW_PER_LINE-1:0][DW_W-1:0]   line_dw;
  logic [OFF_W-1:0]                   dw_off;
  l2c_ans_e                           nxt_type;
  logic [WBB_TAG_W-1:0]               nxt_wbb_tag;
  logic [LINE_W-1:0]                  nxt_line;
  logic [DW_W-1:0]                    nxt_data;

  // Lowest expired slot
  always_comb begin
    sel_idx = '0;
    for (int k = BUF_LEN - 1; k >= 0; k--) begin
      if (expired_i[k]) begin
        sel_idx = BUF_IDX_W'(k);
      end
    end
  end
  assign sel_vld = |expired_i;

  // Register free or drained this cycle
  assign take = sel_vld && (!ans_valid_o || ans_rdy_i);

  always_comb begin
    retire_o = '0;
    if (take) begin
      retire_o[sel_idx] = 1'b1;
    end
  end

  // Memory lookup for the selected line
  assign ridx_o  = paddr_i[sel_idx][LINE_LSB +: MEM_IDX_W];
  assign dw_off  = paddr_i[sel_idx][OFF_LSB +: OFF_W];
  assign line_dw = rline_i;

  // Answer formation, unused fields stay zero
  always_comb begin
    nxt_type    = ILineRead;
    nxt_wbb_tag = '0;
    nxt_line    = '0;
    nxt_data    = '0;
    case (type_i[sel_idx])
      IReadLine: begin
        nxt_type = ILineRead;
        nxt_line = rline_i;
      end
      DReadLine: begin
        nxt_type = DLineRead;
        nxt_line = rline_i;
      end
      DWriteLine: begin
        // A missed write wakes the write-back buffer
        nxt_type    = miss_i[sel_idx] ? DWbbWakeUp : DLineWritten;
        nxt_wbb_tag = wbb_tag_i[sel_idx];
      end
      PTWLoad: begin
        nxt_type = PTWLoadDone;
        nxt_data = line_dw[dw_off];
      end
    endcase
  end

  // Answer valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ans_valid_o <= 1'b0;
    end else if (flush_i) begin
      ans_valid_o <= 1'b0;
    end else if (take) begin
      ans_valid_o <= 1'b1;
    end else if (ans_rdy_i) begin
      ans_valid_o <= 1'b0;
    end
  end

  // Answer payload, held under back-pressure
  always_ff @(posedge clk_i) begin
    if (take) begin
      ans_type_o    <= nxt_type;
      ans_paddr_o   <= paddr_i[sel_idx];
      ans_wbb_tag_o <= nxt_wbb_tag;
      ans_line_o    <= nxt_line;
      ans_data_o    <= nxt_data;
    end
  end

endmodule

// ==== rtl/l2c_line_mem.sv ====
// ************************************************
// L2 cache emulator backing memory
// Line array, sync write and async read
// ************************************************
module l2c_line_mem
  import l2c_cfg_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 we_i,
  input  logic [MEM_IDX_W-1:0] widx_i,
  input  logic [LINE_W-1:0]    wline_i,
  input  logic [MEM_IDX_W-1:0] ridx_i,
  output logic [LINE_W-1:0]    rline_o
);

  // Main memory stand-in
  logic [LINE_W-1:0] mem_q [MEM_LINES];

  // Whole-line write from the request channel
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[widx_i] <= wline_i;
    end
  end

  // Read follows the selected slot in the same cycle
  assign rline_o = mem_q[ridx_i];

endmodule

// ==== rtl/l2c_tag_dir.sv ====
// ************************************************
// L2 cache emulator tag directory
// Direct-mapped lookup deciding hit or miss
// ************************************************
module l2c_tag_dir
  import l2c_cfg_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               accept_i,
  input  logic [PADDR_W-1:0] paddr_i,
  output logic               miss_o
);

  logic [SET_NUM-1:0] valid_q;
  logic [TAG_W-1:0]   tag_q [SET_NUM];
  logic [SET_W-1:0]   set_idx;
  logic [TAG_W-1:0]   req_tag;

  // Address split
  assign set_idx = paddr_i[LINE_LSB +: SET_W];
  assign req_tag = paddr_i[TAG_LSB +: TAG_W];

  // Miss on empty entry or tag mismatch
  assign miss_o = !valid_q[set_idx] || (tag_q[set_idx] != req_tag);

  // Valid bits, all entries empty out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (accept_i) begin
      valid_q[set_idx] <= 1'b1;
    end
  end

  // Every accepted request allocates its set
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      tag_q[set_idx] <= req_tag;
    end
  end

endmodule

// ==== rtl/l2c_req_slot.sv ====
// ************************************************
// L2 cache emulator request slot
// Holds one outstanding request and its latency count
// ************************************************
module l2c_req_slot
  import l2c_cfg_pkg::*;
  import l2c_msg_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 load_i,
  input  logic                 retire_i,
  input  l2c_req_e             req_type_i,
  input  logic [PADDR_W-1:0]   paddr_i,
  input  logic [WBB_TAG_W-1:0] wbb_tag_i,
  input  logic                 miss_i,
  output logic                 busy_o,
  output logic                 expired_o,
  output l2c_req_e             type_o,
  output logic [PADDR_W-1:0]   paddr_o,
  output logic [WBB_TAG_W-1:0] wbb_tag_o,
  output logic                 miss_o
);

  logic                 busy_q;
  logic [CNT_W-1:0]     cnt_q;
  l2c_req_e             type_q;
  logic [PADDR_W-1:0]   paddr_q;
  logic [WBB_TAG_W-1:0] wbb_tag_q;
  logic                 miss_q;

  // Occupancy and countdown
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;
    end else if (load_i) begin
      busy_q <= 1'b1;
      // Latency picked from the tag lookup at accept time
      cnt_q  <= miss_i ? CNT_W'(M_DELAY) : CNT_W'(H_DELAY);
    end else if (retire_i) begin
      busy_q <= 1'b0;
    end else if (busy_q && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Request payload captured on accept
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      type_q    <= req_type_i;
      paddr_q   <= paddr_i;
      wbb_tag_q <= wbb_tag_i;
      miss_q    <= miss_i;
    end
  end

  // Count at zero means the answer may leave
  assign busy_o    = busy_q;
  assign expired_o = busy_q && (cnt_q == '0);
  assign type_o    = type_q;
  assign paddr_o   = paddr_q;
  assign wbb_tag_o = wbb_tag_q;
  assign miss_o    = miss_q;

endmodule

// ==== rtl/l2c_slot_alloc.sv ====
// ************************************************
// L2 cache emulator slot allocator
// Grants the lowest free slot to an incoming request
// ************************************************
module l2c_slot_alloc
  import l2c_cfg_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               req_valid_i,
  input  logic [BUF_LEN-1:0] busy_i,
  output logic [BUF_LEN-1:0] load_o,
  output logic               req_rdy_o
);

  logic [BUF_LEN-1:0]   free;
  logic [BUF_IDX_W-1:0] free_idx;
  logic                 free_any;

  assign free = ~busy_i;

  // Priority encoder where the lowest index wins
  always_comb begin
    free_idx = '0;
    for (int k = BUF_LEN - 1; k >= 0; k--) begin
      if (free[k]) begin
        free_idx = BUF_IDX_W'(k);
      end
    end
  end

  // Ready only depends on slot occupancy
  assign free_any  = |free;
  assign req_rdy_o = free_any;

  // One-hot load masked while flushing
  always_comb begin
    load_o = '0;
    if (req_valid_i && req_rdy_o && !flush_i) begin
      load_o[free_idx] = 1'b1;
    end
  end

endmodule

// ==== rtl/l2c_msg_pkg.sv ====
// ************************************************
// L2 cache emulator message encodings
// Request and answer types on the arbiter channels
// ************************************************
package l2c_msg_pkg;

  // Encoding widths
  localparam int REQ_TYPE_W = 2;
  localparam int ANS_TYPE_W = 3;

  // Requests coming from the L2 arbiter
  typedef enum logic [REQ_TYPE_W-1:0] {
    IReadLine,
    DReadLine,
    DWriteLine,
    PTWLoad
  } l2c_req_e;

  // Answers sent back to the L2 arbiter
  // A line write that missed wakes up the write-back buffer
  typedef enum logic [ANS_TYPE_W-1:0] {
    ILineRead,
    DLineRead,
    DLineWritten,
    DWbbWakeUp,
    PTWLoadDone
  } l2c_ans_e;

endpackage

// ==== rtl/l2c_cfg_pkg.sv ====
// ************************************************
// L2 cache emulator geometry and timing
// Address fields, slot count and answer latencies
// ************************************************
package l2c_cfg_pkg;

  // Address and data widths
  localparam int PADDR_W     = 32;
  localparam int LINE_W      = 512;
  localparam int DW_W        = 64;
  localparam int DW_PER_LINE = LINE_W / DW_W;

  // Doubleword offset inside a line, bits 5..3
  localparam int OFF_LSB = 3;
  localparam int OFF_W   = $clog2(DW_PER_LINE);

  // Set index, bits 9..6
  localparam int LINE_LSB = OFF_LSB + OFF_W;
  localparam int SET_NUM  = 16;
  localparam int SET_W    = $clog2(SET_NUM);

  // Tag, bits 31..10
  localparam int TAG_LSB = LINE_LSB + SET_W;
  localparam int TAG_W   = PADDR_W - TAG_LSB;

  // Backing memory, index taken from bits 11..6
  localparam int MEM_LINES = 64;
  localparam int MEM_IDX_W = $clog2(MEM_LINES);

  // Outstanding request slots
  localparam int BUF_LEN   = 3;
  localparam int BUF_IDX_W = $clog2(BUF_LEN);
  localparam int WBB_TAG_W = 4;

  // Hit and miss latency in cycles
  localparam int H_DELAY = 2;
  localparam int M_DELAY = 7;
  localparam int CNT_W   = $clog2(M_DELAY + 1);

endpackage
